// File: test/modbus_testdata.txt
# crc mode, parity byte, wait, request length, request bytes, reply length, reply bytes
# crc mode 0 good, 1 corrupted, 2 left off; parity byte 1-based, 0 none; crc added to both
0 0 1 6 37 03 00 02 00 03 9 37 03 06 A5 C1 A5 C0 A5 C7
0 0 1 6 37 04 00 05 00 01 5 37 04 02 A5 C6
0 0 1 6 37 06 00 01 00 2A 3 37 86 01
0 0 1 6 37 03 00 00 00 00 3 37 83 03
0 0 1 6 37 03 00 1E 00 05 3 37 83 02
0 0 1 6 12 03 00 00 00 01 0
1 0 1 6 37 03 00 00 00 01 0
0 4 1 6 37 03 00 00 00 01 0
2 0 1 4 37 03 00 00 0
# back-to-back group with a slow fifo
0 0 0 6 37 03 00 08 00 04 11 37 03 08 A5 CB A5 CA A5 C9 A5 C8
0 0 0 6 37 04 00 10 00 02 7 37 04 04 A5 D3 A5 D2
0 0 1 6 37 03 00 1C 00 04 11 37 03 08 A5 DF A5 DE A5 DD A5 DC

// File: flist.f
source/modbusPkg.sv
source/modbusCrc16.sv
source/requestQueueIf.sv
source/modbusFrameParser.sv
source/requestQueue.sv
source/modbusResponder.sv
source/modbusWishboneBridge.sv
test/modbusBridgeChecker.sv
test/modbusBridge_props.sv
test/modbusBridge_tb.sv

// File: Bender.yml
package:
  name: modbus_wishbone_bridge

sources:
  - files:
      - source/modbusPkg.sv
      - source/modbusCrc16.sv
      - source/requestQueueIf.sv
      - source/modbusFrameParser.sv
      - source/requestQueue.sv
      - source/modbusResponder.sv
      - source/modbusWishboneBridge.sv
  - target: test
    files:
      - test/modbusBridgeChecker.sv
      - test/modbusBridge_props.sv
      - test/modbusBridge_tb.sv

// File: test/modbusBridge_tb.sv
// Modbus bridge testbench
`timescale 1ns/1ps
`default_nettype none

module modbusBridge_tb;
    localparam int MAX_FRAMES = 16;
    localparam int MAX_BYTES  = 24;

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  dataIn;
    logic        dataReceived;
    logic        parityError;
    logic        silence;
    logic        receiveReq;
    logic [7:0]  dataOut;
    logic        writeReq;
    logic        writeAck;
    logic [23:0] wbAdrO;
    logic [15:0] wbDatI;
    logic        wbCycO;
    logic        wbStbO;
    logic        wbAckI;

    integer     seed = 32'h20a6d6a8;
    logic       slowAck;
    int         frameCount = 0;
    int         crcMode   [MAX_FRAMES]; // 0 good, 1 corrupted, 2 left off
    int         parityAt  [MAX_FRAMES]; // 1-based byte, 0 for none
    int         waitReply [MAX_FRAMES];
    int         reqLen    [MAX_FRAMES];
    int         replyLen  [MAX_FRAMES];
    logic [7:0] reqBytes   [MAX_FRAMES][MAX_BYTES];
    logic [7:0] replyBytes [MAX_FRAMES][MAX_BYTES];

    always #20 clk = ~clk;

    modbusWishboneBridge i_modbusWishboneBridge (.*);

    modbusBridgeChecker i_modbusBridgeChecker (.*);

    bind modbusWishboneBridge modbusBridge_props #(.ADDRESS_WIDTH(ADDRESS_WIDTH))
        i_bridgeProps (.*);

    // bit-serial CRC-16/MODBUS
    function automatic logic [15:0] crcByte(input logic [15:0] crc, input logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            crc = (crc[0] ^ value[i]) ? ((crc >> 1) ^ 16'hA001) : (crc >> 1);
        end
        return crc;
    endfunction

    task automatic loadFrames();
        int    fd;
        int    code;
        string token;
        string rest;
        fd = $fopen("test/modbus_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file test/modbus_testdata.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            while ($fscanf(fd, "%s", token) == 1) begin
                if (token.getc(0) == "#") begin
                    code = $fgets(rest, fd); // skip comment
                end else begin
                    crcMode[frameCount] = token.atoi();
                    code = $fscanf(fd, "%d %d %d", parityAt[frameCount],
                                   waitReply[frameCount], reqLen[frameCount]);
                    for (int i = 0; i < reqLen[frameCount]; i++) begin
                        code = $fscanf(fd, "%h", reqBytes[frameCount][i]);
                    end
                    code = $fscanf(fd, "%d", replyLen[frameCount]);
                    for (int i = 0; i < replyLen[frameCount]; i++) begin
                        code = $fscanf(fd, "%h", replyBytes[frameCount][i]);
                    end
                    frameCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic sendFrame(input int f);
        logic [15:0] crc;
        int          total;
        crc   = 16'hFFFF;
        total = reqLen[f];
        for (int i = 0; i < reqLen[f]; i++) begin
            crc = crcByte(crc, reqBytes[f][i]);
        end
        if (crcMode[f] != 2) begin
            reqBytes[f][total]     = crc[7:0] ^ ((crcMode[f] == 1) ? 8'h5A : 8'h00);
            reqBytes[f][total + 1] = crc[15:8];
            total += 2;
        end
        // reply is queued before the request goes out
        if (replyLen[f] > 0) begin
            crc = 16'hFFFF;
            for (int i = 0; i < replyLen[f]; i++) begin
                crc = crcByte(crc, replyBytes[f][i]);
                i_modbusBridgeChecker.expectByte(replyBytes[f][i]);
            end
            i_modbusBridgeChecker.expectByte(crc[7:0]);
            i_modbusBridgeChecker.expectByte(crc[15:8]);
        end
        for (int i = 0; i < total; i++) begin
            dataIn       = reqBytes[f][i];
            parityError  = (parityAt[f] == i + 1);
            dataReceived = 1'b1;
            @(negedge clk);
            dataReceived = 1'b0;
            parityError  = 1'b0;
            repeat (3) @(negedge clk);
        end
        silence = 1'b1;
        repeat (2) @(negedge clk);
        silence = 1'b0;
    endtask

    // wishbone slave, 1 to 4 cycles to ack
    initial begin : wishboneSlave
        int waitCycles;
        forever begin
            @(negedge clk);
            if (wbCycO && wbStbO) begin
                waitCycles = 1 + ($unsigned($random(seed)) % 4);
                repeat (waitCycles - 1) @(negedge clk);
                wbDatI = wbAdrO[15:0] ^ 16'hA5C3;
                wbAckI = 1'b1;
                @(negedge clk);
                wbAckI = 1'b0;
            end
        end
    end

    // output fifo, accepts each byte 0 to 3 cycles late
    initial begin : fifoModel
        int delay;
        forever begin
            @(negedge clk);
            if (writeReq) begin
                delay = slowAck ? 3 : ($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk);
                writeAck = 1'b1;
                @(negedge clk);
                writeAck = 1'b0;
            end
        end
    end

    initial begin : watchdog
        @(negedge rst); // frames are loaded by now
        repeat (frameCount * 400) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", frameCount * 400);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int errors;
        rst          = 1'b1;
        dataIn       = 8'h00;
        dataReceived = 1'b0;
        parityError  = 1'b0;
        silence      = 1'b0;
        writeAck     = 1'b0;
        wbDatI       = 16'h0000;
        wbAckI       = 1'b0;
        slowAck      = 1'b0;
        loadFrames();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < frameCount; f++) begin
            if (waitReply[f] == 0) begin
                slowAck = 1'b1; // back-to-back group
            end
            sendFrame(f);
            if (waitReply[f] != 0) begin
                while (i_modbusBridgeChecker.pendingCount() != 0) begin
                    @(negedge clk);
                end
                repeat (10) @(negedge clk);
                slowAck = 1'b0;
            end
        end
        repeat (20) @(negedge clk);
        i_modbusBridgeChecker.reportLeftovers();
        errors = i_modbusBridgeChecker.errorCount()
               + i_modbusWishboneBridge.i_bridgeProps.failCount;
        $display("frames %0d, reply bytes checked %0d, checker errors %0d, assertion errors %0d",
                 frameCount, i_modbusBridgeChecker.checkedCount,
                 i_modbusBridgeChecker.errorCount(),
                 i_modbusWishboneBridge.i_bridgeProps.failCount);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/modbusBridge_props.sv
// Bridge handshake assertions
`timescale 1ns/1ps
`default_nettype none

module modbusBridge_props #(
    parameter int ADDRESS_WIDTH = 24
) (
    input logic                     clk,
    input logic                     rst,
    input logic [7:0]               dataOut,
    input logic                     writeReq,
    input logic                     writeAck,
    input logic [ADDRESS_WIDTH-1:0] wbAdrO,
    input logic                     wbCycO,
    input logic                     wbStbO,
    input logic                     wbAckI
);
    int failCount = 0;

    stbInsideCycle: assert property (@(posedge clk) disable iff (rst) wbStbO |-> wbCycO)
        else begin
            failCount++;
            $error("wbStbO high without wbCycO");
        end

    // byte held until the fifo takes it
    dataHeld: assert property (@(posedge clk) disable iff (rst)
                               writeReq && !writeAck |=> $stable(dataOut))
        else begin
            failCount++;
            $error("dataOut changed before writeAck");
        end

    addressHeld: assert property (@(posedge clk) disable iff (rst)
                                  wbStbO && !wbAckI |=> $stable(wbAdrO))
        else begin
            failCount++;
            $error("wbAdrO changed during a pending read");
        end

endmodule

`default_nettype wire

// File: test/modbusBridgeChecker.sv
// Reply byte checker
`timescale 1ns/1ps
`default_nettype none

module modbusBridgeChecker (
    input logic       clk,
    input logic       rst,
    input logic       dataReceived,
    input logic       receiveReq,
    input logic [7:0] dataOut,
    input logic       writeReq,
    input logic       writeAck
);
    logic [7:0] expected [$];
    logic       lastReceived    = 1'b0;
    int         checkedCount    = 0;
    int         wrongCount      = 0;
    int         unexpectedCount = 0;
    int         missingCount    = 0;
    int         receiveErrors   = 0;

    task automatic expectByte(input logic [7:0] value);
        expected.push_back(value);
    endtask

    function automatic int pendingCount();
        return expected.size();
    endfunction

    function automatic int errorCount();
        return wrongCount + unexpectedCount + missingCount + receiveErrors;
    endfunction

    task automatic reportLeftovers();
        logic [7:0] value;
        while (expected.size() != 0) begin
            value = expected.pop_front();
            $display("reply byte %h was expected but never sent", value);
            missingCount++;
        end
    endtask

    // receiveReq follows dataReceived one cycle late
    always @(posedge clk) begin : compareReceiveReq
        if (!rst && receiveReq !== lastReceived) begin
            receiveErrors++;
            $display("FAILED at %0t: receiveReq = %b, expected %b",
                     $time, receiveReq, lastReceived);
        end
        lastReceived = rst ? 1'b0 : dataReceived;
    end

    // a byte counts when the fifo takes it
    always @(posedge clk) begin : compareByte
        logic [7:0] want;
        if (!rst && writeReq && writeAck) begin
            checkedCount++;
            if (expected.size() == 0) begin
                unexpectedCount++;
                $display("reply byte %h sent at %0t when no reply was due", dataOut, $time);
            end else begin
                want = expected.pop_front();
                if (dataOut !== want) begin
                    wrongCount++;
                    $display("FAILED at %0t: dataOut = %h, expected %h", $time, dataOut, want);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/modbusWishboneBridge.sv
// Modbus RTU to Wishbone bridge
`timescale 1ns/1ps
`default_nettype none

module modbusWishboneBridge
    import modbusPkg::*;
#(
    parameter logic [7:0]               STATION_ADDRESS = 8'h37,
    parameter logic [15:0]              HOLDING_COUNT   = 16'd32,
    parameter logic [15:0]              INPUT_COUNT     = 16'd32,
    parameter int                       ADDRESS_WIDTH   = 24,
    parameter logic [ADDRESS_WIDTH-1:0] HOLDING_OFFSET  = 'hA00000,
    parameter logic [ADDRESS_WIDTH-1:0] INPUT_OFFSET    = 'hA00000,
    parameter int                       QUEUE_DEPTH     = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    // uart receiver
    input  logic [7:0]               dataIn,
    input  logic                     dataReceived,
    input  logic                     parityError,
    input  logic                     silence,
    output logic                     receiveReq,
    // output fifo
    output logic [7:0]               dataOut,
    output logic                     writeReq,
    input  logic                     writeAck,
    // wishbone master, read only
    output logic [ADDRESS_WIDTH-1:0] wbAdrO,
    input  logic [REG_WIDTH-1:0]     wbDatI,
    output logic                     wbCycO,
    output logic                     wbStbO,
    input  logic                     wbAckI
);
    requestQueueIf requests ();

    modbusFrameParser #(
        .STATION_ADDRESS (STATION_ADDRESS),
        .HOLDING_COUNT   (HOLDING_COUNT),
        .INPUT_COUNT     (INPUT_COUNT)
    ) i_modbusFrameParser (
        .clk          (clk),
        .rst          (rst),
        .dataIn       (dataIn),
        .dataReceived (dataReceived),
        .parityError  (parityError),
        .silence      (silence),
        .receiveReq   (receiveReq),
        .queue        (requests.producer)
    );

    requestQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_requestQueue (
        .clk   (clk),
        .rst   (rst),
        .queue (requests.store)
    );

    modbusResponder #(
        .ADDRESS_WIDTH   (ADDRESS_WIDTH),
        .STATION_ADDRESS (STATION_ADDRESS),
        .HOLDING_OFFSET  (HOLDING_OFFSET),
        .INPUT_OFFSET    (INPUT_OFFSET)
    ) i_modbusResponder (
        .clk      (clk),
        .rst      (rst),
        .writeAck (writeAck),
        .wbDatI   (wbDatI),
        .wbAckI   (wbAckI),
        .dataOut  (dataOut),
        .writeReq (writeReq),
        .wbAdrO   (wbAdrO),
        .wbCycO   (wbCycO),
        .wbStbO   (wbStbO),
        .queue    (requests.consumer)
    );

endmodule

`default_nettype wire

// File: source/modbusResponder.sv
// Modbus reply generator with Wishbone reads
`timescale 1ns/1ps
`default_nettype none

module modbusResponder
    import modbusPkg::*;
#(
    parameter int                       ADDRESS_WIDTH   = 24,
    parameter logic [7:0]               STATION_ADDRESS = 8'h37,
    parameter logic [ADDRESS_WIDTH-1:0] HOLDING_OFFSET  = 'hA00000,
    parameter logic [ADDRESS_WIDTH-1:0] INPUT_OFFSET    = 'hA00000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     writeAck,
    input  logic [REG_WIDTH-1:0]     wbDatI,
    input  logic                     wbAckI,
    output logic [7:0]               dataOut,
    output logic                     writeReq,
    output logic [ADDRESS_WIDTH-1:0] wbAdrO,
    output logic                     wbCycO,
    output logic                     wbStbO,
    requestQueueIf.consumer queue
);
    typedef enum logic [3:0] {
        TX_IDLE,
        TX_ADDRESS,
        TX_FUNCTION,
        TX_EXCEPTION,
        TX_BYTE_COUNT,
        TX_WB_READ,
        TX_DATA_HI,
        TX_DATA_LO,
        TX_CRC_LO,
        TX_CRC_HI
    } txState;

    txState       state;
    modbusRequest request;
    logic [7:0]   txByte;
    logic [7:0]   lowByte;
    logic [15:0]  regIndex;
    logic [15:0]  crc;
    logic         byteDone;
    logic         lastReg;
    logic         isException;
    logic         crcEnable;

    assign byteDone    = writeReq && writeAck;
    assign lastReg     = (regIndex + 16'd1 == request.quantity);
    assign isException = (request.exceptionCode != 8'h00);
    assign queue.pop   = (state == TX_IDLE) && !queue.empty;

    // crc bytes go out straight from the accumulator
    assign crcEnable = byteDone && state != TX_CRC_LO && state != TX_CRC_HI;
    assign dataOut   = (state == TX_CRC_LO) ? crc[7:0] :
                       (state == TX_CRC_HI) ? crc[15:8] : txByte;

    modbusCrc16 i_modbusCrc16 (
        .clk    (clk),
        .rst    (rst),
        .clear  (state == TX_IDLE),
        .enable (crcEnable),
        .data   (dataOut),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            writeReq <= 1'b0;
            wbCycO   <= 1'b0;
            wbStbO   <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (!queue.empty) begin
                        request  <= queue.popData;
                        regIndex <= 16'd0;
                        wbAdrO   <= ((queue.popData.functionCode == FUN_READ_HOLDING)
                                     ? HOLDING_OFFSET : INPUT_OFFSET)
                                    + ADDRESS_WIDTH'(queue.popData.startAddress);
                        txByte   <= STATION_ADDRESS;
                        writeReq <= 1'b1;
                        state    <= TX_ADDRESS;
                    end
                end
                TX_ADDRESS: begin
                    if (byteDone) begin
                        txByte <= isException ? {1'b1, request.functionCode[6:0]}
                                              : request.functionCode;
                        state  <= TX_FUNCTION;
                    end
                end
                TX_FUNCTION: begin
                    if (byteDone) begin
                        if (isException) begin
                            txByte <= request.exceptionCode;
                            state  <= TX_EXCEPTION;
                        end else begin
                            txByte <= {request.quantity[6:0], 1'b0}; // two bytes per reg
                            state  <= TX_BYTE_COUNT;
                        end
                    end
                end
                TX_EXCEPTION: begin
                    if (byteDone) begin
                        state <= TX_CRC_LO;
                    end
                end
                TX_BYTE_COUNT: begin
                    if (byteDone) begin
                        writeReq <= 1'b0;
                        wbCycO   <= 1'b1;
                        wbStbO   <= 1'b1;
                        state    <= TX_WB_READ;
                    end
                end
                TX_WB_READ: begin
                    if (wbAckI) begin
                        wbCycO   <= 1'b0;
                        wbStbO   <= 1'b0;
                        txByte   <= wbDatI[15:8];
                        lowByte  <= wbDatI[7:0];
                        writeReq <= 1'b1;
                        state    <= TX_DATA_HI;
                    end
                end
                TX_DATA_HI: begin
                    if (byteDone) begin
                        txByte <= lowByte;
                        state  <= TX_DATA_LO;
                    end
                end
                TX_DATA_LO: begin
                    if (byteDone) begin
                        if (lastReg) begin
                            state <= TX_CRC_LO;
                        end else begin
                            // next register
                            writeReq <= 1'b0;
                            wbCycO   <= 1'b1;
                            wbStbO   <= 1'b1;
                            wbAdrO   <= wbAdrO + 1'b1;
                            regIndex <= regIndex + 16'd1;
                            state    <= TX_WB_READ;
                        end
                    end
                end
                TX_CRC_LO: begin
                    if (byteDone) begin
                        state <= TX_CRC_HI;
                    end
                end
                TX_CRC_HI: begin
                    if (byteDone) begin
                        writeReq <= 1'b0;
                        state    <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/requestQueue.sv
// Accepted request FIFO
`timescale 1ns/1ps
`default_nettype none

module requestQueue
    import modbusPkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    requestQueueIf.store queue
);
    localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    modbusRequest         entries [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0] rdPtr;
    logic [PTR_WIDTH-1:0] wrPtr;
    logic [PTR_WIDTH:0]   count;
    logic                 doPush;
    logic                 doPop;

    assign doPush = queue.push && (count != QUEUE_DEPTH); // full drops the request
    assign doPop  = queue.pop && (count != 0);

    assign queue.empty   = (count == 0);
    assign queue.popData = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + doPush - doPop;
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= queue.pushData;
        end
    end

endmodule

`default_nettype wire

// File: source/modbusFrameParser.sv
// Modbus RTU request parser
`timescale 1ns/1ps
`default_nettype none

module modbusFrameParser
    import modbusPkg::*;
#(
    parameter logic [7:0]  STATION_ADDRESS = 8'h37,
    parameter logic [15:0] HOLDING_COUNT   = 16'd32,
    parameter logic [15:0] INPUT_COUNT     = 16'd32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] dataIn,
    input  logic       dataReceived,
    input  logic       parityError,
    input  logic       silence,
    output logic       receiveReq,
    requestQueueIf.producer queue
);
    typedef enum logic [3:0] {
        RX_ADDRESS,
        RX_FUNCTION,
        RX_START_HI,
        RX_START_LO,
        RX_QUANTITY_HI,
        RX_QUANTITY_LO,
        RX_CRC_LO,
        RX_CRC_HI,
        RX_WAIT
    } rxState;

    rxState      state;
    logic [7:0]  functionCode;
    logic [15:0] startAddress;
    logic [15:0] quantity;
    logic [7:0]  crcLo;
    logic [7:0]  exceptionCode;
    logic [15:0] regCount;
    logic [16:0] endAddress;
    logic [15:0] crc;
    logic        byteValid;
    logic        crcEnable;
    logic        crcClear;

    assign byteValid = dataReceived && !parityError && !silence;
    // crc bytes themselves are not accumulated
    assign crcEnable = byteValid && (state inside {RX_ADDRESS, RX_FUNCTION, RX_START_HI,
                                                   RX_START_LO, RX_QUANTITY_HI,
                                                   RX_QUANTITY_LO});
    assign crcClear  = silence || (byteValid && state == RX_CRC_HI);

    modbusCrc16 i_modbusCrc16 (
        .clk    (clk),
        .rst    (rst),
        .clear  (crcClear),
        .enable (crcEnable),
        .data   (dataIn),
        .crc    (crc)
    );

    assign regCount   = (functionCode == FUN_READ_HOLDING) ? HOLDING_COUNT : INPUT_COUNT;
    assign endAddress = {1'b0, startAddress} + {1'b0, quantity};

    always_comb begin
        if (functionCode != FUN_READ_HOLDING && functionCode != FUN_READ_INPUT) begin
            exceptionCode = EXC_ILLEGAL_FUNCTION;
        end else if (quantity == 16'd0 || quantity > MAX_READ_QUANTITY) begin
            exceptionCode = EXC_ILLEGAL_QUANTITY;
        end else if (endAddress > {1'b0, regCount}) begin
            exceptionCode = EXC_ILLEGAL_ADDRESS;
        end else begin
            exceptionCode = 8'h00;
        end
    end

    assign queue.pushData = '{functionCode:  functionCode,
                              startAddress:  startAddress,
                              quantity:      quantity,
                              exceptionCode: exceptionCode};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RX_ADDRESS;
            receiveReq <= 1'b0;
            queue.push <= 1'b0;
        end else begin
            receiveReq <= dataReceived;
            queue.push <= 1'b0;
            if (silence) begin
                state <= RX_ADDRESS;
            end else if (dataReceived) begin
                if (parityError) begin
                    state <= RX_WAIT; // drop rest of frame
                end else begin
                    case (state)
                        RX_ADDRESS:     state <= (dataIn == STATION_ADDRESS) ? RX_FUNCTION
                                                                             : RX_WAIT;
                        RX_FUNCTION:    state <= RX_START_HI;
                        RX_START_HI:    state <= RX_START_LO;
                        RX_START_LO:    state <= RX_QUANTITY_HI;
                        RX_QUANTITY_HI: state <= RX_QUANTITY_LO;
                        RX_QUANTITY_LO: state <= RX_CRC_LO;
                        RX_CRC_LO:      state <= RX_CRC_HI;
                        RX_CRC_HI: begin
                            queue.push <= ({dataIn, crcLo} == crc);
                            state      <= RX_ADDRESS;
                        end
                        default: ; // wait for silence
                    endcase
                end
            end
        end
    end

    // frame fields, big-endian on the wire
    always_ff @(posedge clk) begin
        if (byteValid) begin
            case (state)
                RX_FUNCTION:    functionCode       <= dataIn;
                RX_START_HI:    startAddress[15:8] <= dataIn;
                RX_START_LO:    startAddress[7:0]  <= dataIn;
                RX_QUANTITY_HI: quantity[15:8]     <= dataIn;
                RX_QUANTITY_LO: quantity[7:0]      <= dataIn;
                RX_CRC_LO:      crcLo              <= dataIn;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/requestQueueIf.sv
// Request queue interface
`timescale 1ns/1ps
`default_nettype none

interface requestQueueIf
    import modbusPkg::*;
();
    logic         push;
    logic         pop;
    logic         empty;
    modbusRequest pushData;
    modbusRequest popData; // head entry, valid while !empty

    modport producer (output push, pushData);
    modport store    (input push, pushData, pop, output popData, empty);
    modport consumer (output pop, input popData, empty);

endinterface

`default_nettype wire

// File: source/modbusCrc16.sv
// Modbus CRC-16 accumulator
`timescale 1ns/1ps
`default_nettype none

module modbusCrc16
    import modbusPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        enable,
    input  logic [7:0]  data,
    output logic [15:0] crc
);
    logic [15:0] nextCrc;

    // lsb first, one byte per enable
    always_comb begin
        nextCrc = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            if (nextCrc[0]) begin
                nextCrc = (nextCrc >> 1) ^ CRC_POLY;
            end else begin
                nextCrc = nextCrc >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= CRC_INIT;
        end else if (enable) begin
            crc <= nextCrc;
        end
    end

endmodule

`default_nettype wire

// File: source/modbusPkg.sv
// Modbus bridge definitions
`default_nettype none

package modbusPkg;

    // supported function codes
    localparam logic [7:0] FUN_READ_HOLDING = 8'h03;
    localparam logic [7:0] FUN_READ_INPUT   = 8'h04;

    // exception codes
    localparam logic [7:0] EXC_ILLEGAL_FUNCTION = 8'h01;
    localparam logic [7:0] EXC_ILLEGAL_ADDRESS  = 8'h02;
    localparam logic [7:0] EXC_ILLEGAL_QUANTITY = 8'h03;

    localparam logic [15:0] MAX_READ_QUANTITY = 16'd125;

    // reflected CRC-16/MODBUS
    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'hA001;

    localparam int REG_WIDTH = 16;

    // one accepted request, exceptionCode zero for a normal reply
    typedef struct packed {
        logic [7:0]  functionCode;
        logic [15:0] startAddress;
        logic [15:0] quantity;
        logic [7:0]  exceptionCode;
    } modbusRequest;

endpackage

`default_nettype wire
